// ==== fft_post_top.f ====
src/fft_types_pkg.sv
src/fft_regs_pkg.sv
src/fft_settings.sv
src/fft_shift.sv
src/cordic_prerotate.sv
src/cordic_stage.sv
src/spectrum_output.sv
src/fft_post_top.sv
test/tb_fft_post_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is zero only when the pass message shows up in the output.
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fft_post_top -f fft_post_top.f -o sim_tb && \
./obj_dir/sim_tb | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null && \
echo "simulation result: pass" || { echo "simulation result: fail"; exit 1; }

// ==== src/cordic_prerotate.sv ====
// Folds each sample into the right half-plane ahead of the vectoring stages.
// A 180 degree turn keeps the magnitude, so no angle is tracked.
`timescale 1ns/1ps

module cordic_prerotate
  import fft_types_pkg::*;
(
  input  logic         ce_clk,
  input  logic         i_reset,
  input  beat_t        i_beat,
  output cordic_beat_t o_stage
);

  logic signed [CORDIC_W-1:0] x_ext;
  logic signed [CORDIC_W-1:0] y_ext;
  logic signed [CORDIC_W-1:0] x_q;
  logic signed [CORDIC_W-1:0] y_q;
  logic                       valid_q;
  logic                       last_q;

  // Sign extension into the growth bits
  assign x_ext = {{(CORDIC_W-16){i_beat.sample.i[15]}}, i_beat.sample.i};
  assign y_ext = {{(CORDIC_W-16){i_beat.sample.q[15]}}, i_beat.sample.q};

  always_ff @(posedge ce_clk) begin
    if (x_ext[CORDIC_W-1]) begin
      x_q <= -x_ext;
      y_q <= -y_ext;
    end else begin
      x_q <= x_ext;
      y_q <= y_ext;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= i_beat.valid;
      last_q  <= i_beat.last;
    end
  end

  assign o_stage = '{x: x_q, y: y_q, valid: valid_q, last: last_q};

endmodule

// ==== src/cordic_stage.sv ====
// One registered CORDIC vectoring micro-rotation by 2^-SHIFT.
// Expects x >= 0 on entry; rotates y toward zero.
`timescale 1ns/1ps

module cordic_stage
  import fft_types_pkg::*;
#(
  parameter int SHIFT = 0
) (
  input  logic         ce_clk,
  input  logic         i_reset,
  input  cordic_beat_t i_stage,
  output cordic_beat_t o_stage
);

  logic signed [CORDIC_W-1:0] x_in;
  logic signed [CORDIC_W-1:0] y_in;
  logic signed [CORDIC_W-1:0] x_sh;
  logic signed [CORDIC_W-1:0] y_sh;
  logic signed [CORDIC_W-1:0] x_next;
  logic signed [CORDIC_W-1:0] y_next;
  logic signed [CORDIC_W-1:0] x_q;
  logic signed [CORDIC_W-1:0] y_q;
  logic                       valid_q;
  logic                       last_q;

  assign x_in = i_stage.x;
  assign y_in = i_stage.y;
  assign x_sh = x_in >>> SHIFT;
  assign y_sh = y_in >>> SHIFT;

  // Direction from the sign of y
  always_comb begin
    if (!y_in[CORDIC_W-1]) begin
      x_next = x_in + y_sh;
      y_next = y_in - x_sh;
    end else begin
      x_next = x_in - y_sh;
      y_next = y_in + x_sh;
    end
  end

  always_ff @(posedge ce_clk) begin
    x_q <= x_next;
    y_q <= y_next;
  end

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= i_stage.valid;
      last_q  <= i_stage.last;
    end
  end

  assign o_stage = '{x: x_q, y: y_q, valid: valid_q, last: last_q};

endmodule

// ==== src/fft_post_top.sv ====
// Post-processing back end of a streaming FFT: settings, FFT shift, magnitude.
// Latency is 2 cycles in complex mode and 16 in magnitude mode. No back-pressure.
`timescale 1ns/1ps

module fft_post_top
  import fft_types_pkg::*;
  import fft_regs_pkg::*;
(
  input  logic         ce_clk,
  input  logic         fft_reset_trigger,
  input  setting_bus_t i_set,
  input  beat_t        i_beat,
  output out_word_u    o_word,
  output logic         o_valid,
  output logic         o_last
);

  logic                   core_reset;
  logic [SIZE_LOG2_W-1:0] size_log2;
  logic                   mag_mode;
  beat_t                  shift_beat;

  // Element 0 from prerotate, last element into the output stage
  cordic_beat_t stage_chain [0:NUM_CORDIC_STAGES];

  fft_settings u_settings (
    .ce_clk            (ce_clk),
    .fft_reset_trigger (fft_reset_trigger),
    .i_set             (i_set),
    .o_core_reset      (core_reset),
    .o_size_log2       (size_log2),
    .o_mag_mode        (mag_mode)
  );

  fft_shift u_shift (
    .ce_clk      (ce_clk),
    .i_reset     (core_reset),
    .i_size_log2 (size_log2),
    .i_beat      (i_beat),
    .o_beat      (shift_beat)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Magnitude pipeline
  ////////////////////////////////////////////////////////////////////////////

  cordic_prerotate u_prerotate (
    .ce_clk  (ce_clk),
    .i_reset (core_reset),
    .i_beat  (shift_beat),
    .o_stage (stage_chain[0])
  );

  for (genvar s = 0; s < NUM_CORDIC_STAGES; s++) begin : g_cordic
    cordic_stage #(.SHIFT(s)) u_stage (
      .ce_clk  (ce_clk),
      .i_reset (core_reset),
      .i_stage (stage_chain[s]),
      .o_stage (stage_chain[s+1])
    );
  end

  spectrum_output u_output (
    .ce_clk       (ce_clk),
    .i_reset      (core_reset),
    .i_mag_mode   (mag_mode),
    .i_shift_beat (shift_beat),
    .i_stage      (stage_chain[NUM_CORDIC_STAGES]),
    .o_word       (o_word),
    .o_valid      (o_valid),
    .o_last       (o_last)
  );

endmodule

// ==== src/fft_regs_pkg.sv ====
// Settings-bus layout, register map and reset defaults of the FFT back end.
// Size and mode writes are only legal between frames.

package fft_regs_pkg;

  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } setting_bus_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  // Any write here pulses the core reset, data ignored
  localparam logic [7:0] SR_FFT_RESET     = 8'd131;

  // Data bits 3:0 carry the size log2
  localparam logic [7:0] SR_FFT_SIZE_LOG2 = 8'd132;

  // Data bit 0 selects magnitude output
  localparam logic [7:0] SR_MAGNITUDE_OUT = 8'd133;

  ////////////////////////////////////////////////////////////////////////////
  // Defaults
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [3:0] DEFAULT_SIZE_LOG2 = 4'd8;

  // Width of the core reset pulse in clock cycles
  localparam int         FFT_RESET_CYCLES  = 2;

endpackage

// ==== src/fft_settings.sv ====
// Settings decode for the FFT back end. Out-of-range sizes are clamped to 3..8.
// The core reset is the system reset ORed with a two-cycle stretched pulse.
`timescale 1ns/1ps

module fft_settings
  import fft_types_pkg::*;
  import fft_regs_pkg::*;
(
  input  logic                   ce_clk,
  input  logic                   fft_reset_trigger,
  input  setting_bus_t           i_set,
  output logic                   o_core_reset,
  output logic [SIZE_LOG2_W-1:0] o_size_log2,
  output logic                   o_mag_mode
);

  logic                        wr_reset;
  logic                        wr_size;
  logic                        wr_mode;
  logic [3:0]                  size_req;
  logic [SIZE_LOG2_W-1:0]      size_clamped;
  logic [FFT_RESET_CYCLES-1:0] reset_sr;
  logic                        stretch;

  assign wr_reset = i_set.stb && (i_set.addr == SR_FFT_RESET);
  assign wr_size  = i_set.stb && (i_set.addr == SR_FFT_SIZE_LOG2);
  assign wr_mode  = i_set.stb && (i_set.addr == SR_MAGNITUDE_OUT);
  assign size_req = i_set.data[3:0];

  // Keep the requested size inside the buffer range
  always_comb begin
    if (size_req < 4'(MIN_FFT_SIZE_LOG2)) begin
      size_clamped = SIZE_LOG2_W'(MIN_FFT_SIZE_LOG2);
    end else if (size_req > 4'(MAX_FFT_SIZE_LOG2)) begin
      size_clamped = SIZE_LOG2_W'(MAX_FFT_SIZE_LOG2);
    end else begin
      size_clamped = SIZE_LOG2_W'(size_req);
    end
  end

  always_ff @(posedge ce_clk) begin
    if (fft_reset_trigger) begin
      o_size_log2 <= SIZE_LOG2_W'(DEFAULT_SIZE_LOG2);
      o_mag_mode  <= 1'b0;
    end else begin
      if (wr_size) begin
        o_size_log2 <= size_clamped;
      end
      if (wr_mode) begin
        o_mag_mode <= i_set.data[0];
      end
    end
  end

  // Pulse stretcher, loads all ones and drains from the top bit
  always_ff @(posedge ce_clk) begin
    if (fft_reset_trigger) begin
      reset_sr <= '0;
    end else if (wr_reset) begin
      reset_sr <= '1;
    end else begin
      reset_sr <= {reset_sr[FFT_RESET_CYCLES-2:0], 1'b0};
    end
  end

  assign stretch      = reset_sr[FFT_RESET_CYCLES-1];
  assign o_core_reset = fft_reset_trigger | stretch;

  a_reset_held: assert property (@(posedge ce_clk) disable iff (fft_reset_trigger)
    wr_reset |=> stretch [*FFT_RESET_CYCLES])
    else $error("core reset dropped early");

  a_reset_release: assert property (@(posedge ce_clk) disable iff (fft_reset_trigger)
    wr_reset ##1 (!wr_reset) [*FFT_RESET_CYCLES] |=> !stretch)
    else $error("core reset held too long");

endmodule

// ==== src/fft_shift.sv ====
// Ping-pong frame buffer that moves the DC bin to the centre of the frame.
// Frames must be exactly 2^size beats, and a new frame may only finish once
// the previous readout is on its final beat. No back-pressure.
`timescale 1ns/1ps

module fft_shift
  import fft_types_pkg::*;
(
  input  logic                   ce_clk,
  input  logic                   i_reset,
  input  logic [SIZE_LOG2_W-1:0] i_size_log2,
  input  beat_t                  i_beat,
  output beat_t                  o_beat
);

  localparam int IDX_W = MAX_FFT_SIZE_LOG2;

  // Bank select is the top address bit
  cplx_t mem [0:2*MAX_FFT_SIZE-1];

  logic [IDX_W:0]   frame_len;
  logic [IDX_W-1:0] last_idx;
  logic [IDX_W-1:0] half_mask;
  logic             wr_bank;
  logic [IDX_W-1:0] wr_idx;
  logic             rd_bank;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] rd_addr;
  logic             rd_active;
  cplx_t            out_sample;
  logic             out_valid;
  logic             out_last;

  assign frame_len = (IDX_W+1)'(1) << i_size_log2;
  assign last_idx  = IDX_W'(frame_len - 1'b1);
  assign half_mask = IDX_W'(frame_len >> 1);

  // Upper half of the spectrum comes out first
  assign rd_addr = rd_idx ^ half_mask;

  ////////////////////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_beat.valid) begin
      mem[{wr_bank, wr_idx}] <= i_beat.sample;
    end
  end

  // Readout of a finished bank, a new last overrides the end of the old one
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      wr_bank   <= 1'b0;
      wr_idx    <= '0;
      rd_bank   <= 1'b0;
      rd_idx    <= '0;
      rd_active <= 1'b0;
    end else begin
      if (rd_active) begin
        rd_idx <= rd_idx + 1'b1;
        if (rd_idx == last_idx) begin
          rd_active <= 1'b0;
        end
      end
      if (i_beat.valid) begin
        if (i_beat.last) begin
          wr_bank   <= ~wr_bank;
          wr_idx    <= '0;
          rd_bank   <= wr_bank;
          rd_idx    <= '0;
          rd_active <= 1'b1;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    out_sample <= mem[{rd_bank, rd_addr}];
  end

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= rd_active;
      out_last  <= rd_active && (rd_idx == last_idx);
    end
  end

  assign o_beat = '{sample: out_sample, valid: out_valid, last: out_last};

  a_last_position: assert property (@(posedge ce_clk) disable iff (i_reset)
    i_beat.valid |-> (i_beat.last == (wr_idx == last_idx)))
    else $error("input last not on beat 2^size");

  a_no_overrun: assert property (@(posedge ce_clk) disable iff (i_reset)
    (i_beat.valid && i_beat.last) |-> (!rd_active || (rd_idx == last_idx)))
    else $error("frame completed while previous readout pending");

endmodule

// ==== src/fft_types_pkg.sv ====
// Sample, beat and output-word types shared by the FFT post-processing path.
// Frame sizes run from 8 to 256 points. CORDIC words carry two growth bits.

package fft_types_pkg;

  // Frame size limits, as log2
  localparam int MAX_FFT_SIZE_LOG2 = 8;
  localparam int MIN_FFT_SIZE_LOG2 = 3;
  localparam int MAX_FFT_SIZE      = 1 << MAX_FFT_SIZE_LOG2;
  localparam int SIZE_LOG2_W       = $clog2(MAX_FFT_SIZE_LOG2 + 1);

  // CORDIC vectoring pipeline
  localparam int          NUM_CORDIC_STAGES = 12;
  localparam int          CORDIC_W          = 18;
  // 0.60725 as an unsigned 16-bit fraction
  localparam logic [15:0] CORDIC_GAIN_Q16   = 16'd39797;
  localparam logic [14:0] MAG_MAX           = 15'h7FFF;

  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } cplx_t;

  typedef struct packed {
    cplx_t sample;
    logic  valid;
    logic  last;
  } beat_t;

  typedef struct packed {
    logic signed [CORDIC_W-1:0] x;
    logic signed [CORDIC_W-1:0] y;
    logic                       valid;
    logic                       last;
  } cordic_beat_t;

  // Magnitude sits in the real half, imaginary half stays zero
  typedef struct packed {
    logic        zero;
    logic [14:0] mag;
    logic [15:0] pad;
  } mag_view_t;

  typedef union packed {
    cplx_t     cplx;
    mag_view_t mag;
  } out_word_u;

endpackage

// ==== src/spectrum_output.sv ====
// Gain correction and output select. Magnitude is rounded and saturated to 15 bits.
// Mode changes are only legal while the block is idle.
`timescale 1ns/1ps

module spectrum_output
  import fft_types_pkg::*;
(
  input  logic         ce_clk,
  input  logic         i_reset,
  input  logic         i_mag_mode,
  input  beat_t        i_shift_beat,
  input  cordic_beat_t i_stage,
  output out_word_u    o_word,
  output logic         o_valid,
  output logic         o_last
);

  // Half an LSB of the Q16 product
  localparam logic [CORDIC_W+15:0] ROUND_HALF = (CORDIC_W+16)'(32768);

  logic [CORDIC_W-1:0]    x_pos;
  logic [CORDIC_W+15:0]   product;
  logic [CORDIC_W-1:0]    rounded;
  logic [14:0]            mag_sat;
  logic [14:0]            mag_q;
  logic                   mag_valid;
  logic                   mag_last;
  out_word_u              next_word;
  logic                   sel_valid;
  logic                   sel_last;

  ////////////////////////////////////////////////////////////////////////////
  // Scale stage
  ////////////////////////////////////////////////////////////////////////////

  // Vectoring keeps x non-negative; a negative x clips to zero
  assign x_pos   = i_stage.x[CORDIC_W-1] ? '0 : CORDIC_W'(i_stage.x);
  assign product = x_pos * CORDIC_GAIN_Q16;
  assign rounded = CORDIC_W'((product + ROUND_HALF) >> 16);
  assign mag_sat = (rounded > CORDIC_W'(MAG_MAX)) ? MAG_MAX : rounded[14:0];

  always_ff @(posedge ce_clk) begin
    mag_q <= mag_sat;
  end

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      mag_valid <= 1'b0;
      mag_last  <= 1'b0;
    end else begin
      mag_valid <= i_stage.valid;
      mag_last  <= i_stage.last;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_word = '0;
    if (i_mag_mode) begin
      next_word.mag.zero = 1'b0;
      next_word.mag.mag  = mag_q;
      next_word.mag.pad  = '0;
    end else begin
      next_word.cplx = i_shift_beat.sample;
    end
  end

  assign sel_valid = i_mag_mode ? mag_valid : i_shift_beat.valid;
  assign sel_last  = i_mag_mode ? mag_last  : i_shift_beat.last;

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_word  <= '0;
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end else begin
      o_valid <= sel_valid;
      o_last  <= sel_last;
      if (sel_valid) begin
        o_word <= next_word;
      end
    end
  end

  // Mode may only move while neither input path carries a beat
  a_mode_idle: assert property (@(posedge ce_clk) disable iff (i_reset)
    (i_mag_mode != $past(i_mag_mode)) |->
      !(i_shift_beat.valid || i_stage.valid || mag_valid))
    else $error("output mode changed with a beat in flight");

endmodule

// ==== test/tb_fft_post_top.sv ====
// Table-driven testbench for the FFT back end. Outputs are gathered in a queue,
// so frame timing is not pinned to exact cycles. Magnitude is accepted within 3 LSB.
`timescale 1ns/1ps

module tb_fft_post_top
  import fft_types_pkg::*;
  import fft_regs_pkg::*;
();

  localparam int NUM_ROWS     = 8;
  localparam int RESET_CYCLES = 10;
  localparam int MAG_TOL      = 3;

  typedef struct packed {
    logic [3:0] size_req;
    logic       write_cfg;
    logic       mag;
    logic       mid_reset;
    logic       rand_data;
    logic [3:0] frames;
  } row_t;

  logic         ce_clk;
  logic         fft_reset_trigger;
  setting_bus_t i_set;
  beat_t        i_beat;
  out_word_u    o_word;
  logic         o_valid;
  logic         o_last;

  row_t      rows [NUM_ROWS];
  string     row_names [NUM_ROWS];
  cplx_t     sent [$];
  out_word_u word_q [$];
  logic      last_q [$];

  int errors        = 0;
  int tests_run     = 0;
  int tests_failed  = 0;
  int cycle_count   = 0;
  int timeout_limit = 1000000;

  fft_post_top u_dut (
    .ce_clk            (ce_clk),
    .fft_reset_trigger (fft_reset_trigger),
    .i_set             (i_set),
    .i_beat            (i_beat),
    .o_word            (o_word),
    .o_valid           (o_valid),
    .o_last            (o_last)
  );

  initial begin
    ce_clk = 1'b0;
    forever #10 ce_clk = ~ce_clk;
  end

  // Outputs only move on the rising edge
  always @(negedge ce_clk) begin
    if (o_valid) begin
      word_q.push_back(o_word);
      last_q.push_back(o_last);
    end
  end

  always @(posedge ce_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_table();
    rows[0] = '{size_req: 4'd8, write_cfg: 1'b0, mag: 1'b0, mid_reset: 1'b0,
                rand_data: 1'b0, frames: 4'd1};
    rows[1] = '{size_req: 4'd3, write_cfg: 1'b1, mag: 1'b0, mid_reset: 1'b0,
                rand_data: 1'b0, frames: 4'd1};
    rows[2] = '{size_req: 4'd4, write_cfg: 1'b1, mag: 1'b0, mid_reset: 1'b0,
                rand_data: 1'b0, frames: 4'd1};
    rows[3] = '{size_req: 4'd3, write_cfg: 1'b1, mag: 1'b0, mid_reset: 1'b0,
                rand_data: 1'b1, frames: 4'd4};
    rows[4] = '{size_req: 4'd4, write_cfg: 1'b1, mag: 1'b1, mid_reset: 1'b0,
                rand_data: 1'b1, frames: 4'd2};
    // Settings from the row above must survive the core reset
    rows[5] = '{size_req: 4'd4, write_cfg: 1'b0, mag: 1'b1, mid_reset: 1'b1,
                rand_data: 1'b1, frames: 4'd1};
    rows[6] = '{size_req: 4'd2, write_cfg: 1'b1, mag: 1'b0, mid_reset: 1'b0,
                rand_data: 1'b0, frames: 4'd1};
    rows[7] = '{size_req: 4'd12, write_cfg: 1'b1, mag: 1'b0, mid_reset: 1'b0,
                rand_data: 1'b0, frames: 4'd1};
    row_names[0] = "default size 256, complex, ramp";
    row_names[1] = "size 8, complex, ramp";
    row_names[2] = "size 16, complex, ramp";
    row_names[3] = "back-to-back size 8, random";
    row_names[4] = "magnitude size 16, random";
    row_names[5] = "core reset mid-frame, magnitude size 16";
    row_names[6] = "size write 2 clamped to 8 points";
    row_names[7] = "size write 12 clamped to 256 points";
  endtask

  function automatic int clamp_size(input logic [3:0] req);
    if (int'(req) < MIN_FFT_SIZE_LOG2) begin
      return MIN_FFT_SIZE_LOG2;
    end
    if (int'(req) > MAX_FFT_SIZE_LOG2) begin
      return MAX_FFT_SIZE_LOG2;
    end
    return int'(req);
  endfunction

  // Each row sends its frames and any partial frame, then drains one frame of readout
  function automatic int run_limit();
    int total;
    int len;
    total = RESET_CYCLES + 40;
    foreach (rows[r]) begin
      len   = 1 << clamp_size(rows[r].size_req);
      total = total + (int'(rows[r].frames) + int'(rows[r].mid_reset) + 1) * len + 60;
    end
    return total;
  endfunction

  function automatic int expected_mag(input cplx_t s);
    longint sq;
    real    root;
    int     m;
    sq   = longint'(s.i) * longint'(s.i) + longint'(s.q) * longint'(s.q);
    root = $sqrt(real'(sq));
    m    = int'(root);
    if (m > 32767) begin
      m = 32767;
    end
    return m;
  endfunction

  // Extremes show up often enough to hit saturation and sign folding
  function automatic logic signed [15:0] random_value();
    int unsigned pick;
    logic signed [15:0] v;
    pick = $urandom % 8;
    case (pick)
      0:       v = 16'sh8000;
      1:       v = 16'sh7FFF;
      default: v = 16'($urandom);
    endcase
    return v;
  endfunction

  function automatic cplx_t make_sample(input logic rnd, input int idx);
    cplx_t s;
    if (rnd) begin
      s.i = random_value();
      s.q = random_value();
    end else begin
      s.i = 16'(idx * 3 + 1);
      s.q = 16'(-idx);
    end
    return s;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_cplx(input string name, input cplx_t got, input cplx_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_mag(input string name, input out_word_u got, input int exp_mag);
    int diff;
    diff = int'(got.mag.mag) - exp_mag;
    if (got.mag.zero !== 1'b0) begin
      errors++;
      $display("CHECK FAILED %s.zero got %h expected 0", name, got.mag.zero);
    end
    if (got.cplx.q !== 16'h0000) begin
      errors++;
      $display("CHECK FAILED %s.q got %h expected 0000", name, got.cplx.q);
    end
    if (diff > MAG_TOL || diff < -MAG_TOL) begin
      errors++;
      $display("CHECK FAILED %s.mag got %h expected %h", name, got.mag.mag, 15'(exp_mag));
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge ce_clk);
      i_beat = '0;
    end
  endtask

  task automatic send_beat(input cplx_t s, input logic last);
    @(negedge ce_clk);
    i_beat = '{sample: s, valid: 1'b1, last: last};
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge ce_clk);
    i_set = '{stb: 1'b1, addr: addr, data: data};
    @(negedge ce_clk);
    i_set = '0;
  endtask

  // Wait for the expected beats and a little longer to catch extras
  task automatic collect(input int expected, input int bound);
    int waited;
    waited = 0;
    while (word_q.size() < expected && waited < bound) begin
      @(negedge ce_clk);
      waited++;
    end
    repeat (20) @(negedge ce_clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d (%s): ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d (%s): %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  // Output bin k of a frame is input bin k XOR half the frame length
  task automatic check_frames(input int len, input logic mag);
    int    n;
    int    got_n;
    int    k;
    int    b;
    cplx_t src;
    n     = sent.size();
    got_n = word_q.size();
    if (got_n < n) begin
      errors++;
      $display("Output short: only %0d of %0d beats arrived", got_n, n);
    end else if (got_n > n) begin
      errors++;
      $display("Output has %0d extra beats beyond the %0d expected", got_n - n, n);
    end
    for (k = 0; k < n && k < got_n; k++) begin
      b   = k % len;
      src = sent[(k / len) * len + (b ^ (len / 2))];
      if (mag) begin
        check_mag($sformatf("o_word[%0d]", k), word_q[k], expected_mag(src));
      end else begin
        check_cplx($sformatf("o_word[%0d]", k), word_q[k].cplx, src);
      end
      check_last($sformatf("o_last[%0d]", k), last_q[k], b == len - 1);
    end
  endtask

  task automatic check_reset_idle();
    int errs_before;
    errs_before = errors;
    @(negedge ce_clk);
    check_cplx("o_word", o_word.cplx, '0);
    check_last("o_last", o_last, 1'b0);
    repeat (20) @(negedge ce_clk);
    if (word_q.size() != 0) begin
      errors++;
      $display("o_valid went high %0d times with no input applied", word_q.size());
    end
    report_test("idle after reset", errs_before);
  endtask

  task automatic run_row(input int idx);
    row_t  r;
    int    len;
    int    f;
    int    k;
    int    errs_before;
    cplx_t s;
    r           = rows[idx];
    len         = 1 << clamp_size(r.size_req);
    errs_before = errors;
    sent.delete();
    word_q.delete();
    last_q.delete();
    if (r.write_cfg) begin
      write_reg(SR_FFT_SIZE_LOG2, {28'd0, r.size_req});
      write_reg(SR_MAGNITUDE_OUT, {31'd0, r.mag});
      idle_cycles(2);
    end
    // Half a frame that the core reset throws away
    if (r.mid_reset) begin
      for (k = 0; k < len / 2; k++) begin
        send_beat(make_sample(r.rand_data, k), 1'b0);
      end
      idle_cycles(1);
      write_reg(SR_FFT_RESET, 32'd0);
      idle_cycles(4);
    end
    for (f = 0; f < int'(r.frames); f++) begin
      for (k = 0; k < len; k++) begin
        s = make_sample(r.rand_data, f * len + k);
        sent.push_back(s);
        send_beat(s, k == len - 1);
      end
    end
    idle_cycles(1);
    collect(sent.size(), int'(r.frames) * len + 40);
    check_frames(len, r.mag);
    report_test(row_names[idx], errs_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    fft_reset_trigger = 1'b1;
    i_set             = '0;
    i_beat            = '0;
    void'($urandom(13079));
    load_table();
    timeout_limit = run_limit();

    repeat (RESET_CYCLES) @(posedge ce_clk);
    @(negedge ce_clk);
    fft_reset_trigger = 1'b0;

    check_reset_idle();
    for (int idx = 0; idx < NUM_ROWS; idx++) begin
      run_row(idx);
    end

    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
